//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // Data path and address width.
    localparam int XLEN = 64;

    // Register address width, fixed by the ISA.
    localparam int REG_AW = 5;

    // Major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ALU operations. ADD is zero so a bubble maps onto it.
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    // Source of the value written back to rd.
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    // Function codes used by the decoder.
    localparam logic [6:0] FUNC7_BASE = 7'b0000000;
    localparam logic [6:0] FUNC7_ALT  = 7'b0100000;
    localparam logic [2:0] FUNC3_DW   = 3'b011;

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

    // Control fields produced by the decoder. All zero is a bubble.
    typedef struct packed {
        rv_isa_pkg::alu_op_e     alu_op;
        rv_isa_pkg::result_src_e result_src;
        logic                    alu_src;
        logic                    reg_we;
        logic                    mem_we;
        logic                    mem_access;
        logic                    branch;
        logic                    jump;
        logic                    branch_ne;
        logic                    load_instr;
    } ctrl_t;

    // One decoded instruction travelling from decode to execute.
    typedef struct packed {
        ctrl_t                           ctrl;
        logic [rv_isa_pkg::XLEN-1:0]     pc;
        logic [rv_isa_pkg::XLEN-1:0]     pc_plus4;
        logic [rv_isa_pkg::XLEN-1:0]     imm_ext;
        logic [rv_isa_pkg::XLEN-1:0]     rs1_data;
        logic [rv_isa_pkg::XLEN-1:0]     rs2_data;
        logic [rv_isa_pkg::REG_AW-1:0]   rs1_addr;
        logic [rv_isa_pkg::REG_AW-1:0]   rs2_addr;
        logic [rv_isa_pkg::REG_AW-1:0]   rd_addr;
        logic [2:0]                      func3;
    } id_ex_t;

    // Register file write request from the later stages.
    typedef struct packed {
        logic                            we;
        logic [rv_isa_pkg::REG_AW-1:0]   addr;
        logic [rv_isa_pkg::XLEN-1:0]     data;
    } wb_t;

    // What execute hands on to the memory stage.
    typedef struct packed {
        logic                            reg_we;
        logic [rv_isa_pkg::REG_AW-1:0]   rd_addr;
        logic [rv_isa_pkg::XLEN-1:0]     result;
        logic                            mem_we;
        logic                            mem_access;
        logic                            load_instr;
        logic [rv_isa_pkg::XLEN-1:0]     store_data;
    } ex_out_t;

endpackage

//--- src/instr_decoder.sv
module instr_decoder (
    input  logic [31:0]                   i_instr,
    output pipe_pkg::ctrl_t               o_ctrl,
    output logic [rv_isa_pkg::XLEN-1:0]   o_imm_ext
);

    localparam int XLEN = rv_isa_pkg::XLEN;

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;

    assign opcode = i_instr[6:0];
    assign func3  = i_instr[14:12];
    assign func7  = i_instr[31:25];

    always_comb begin
        o_ctrl = '0;
        case (rv_isa_pkg::opcode_e'(opcode))
            rv_isa_pkg::OPC_OP: begin
                // Only SUB uses the alternate func7; everything else needs zero.
                o_ctrl.reg_we = 1'b1;
                case (func3)
                    3'b000: begin
                        if (func7 == rv_isa_pkg::FUNC7_ALT) begin
                            o_ctrl.alu_op = rv_isa_pkg::ALU_SUB;
                        end else begin
                            o_ctrl.alu_op = rv_isa_pkg::ALU_ADD;
                        end
                    end
                    3'b111:  o_ctrl.alu_op = rv_isa_pkg::ALU_AND;
                    3'b110:  o_ctrl.alu_op = rv_isa_pkg::ALU_OR;
                    3'b100:  o_ctrl.alu_op = rv_isa_pkg::ALU_XOR;
                    3'b010:  o_ctrl.alu_op = rv_isa_pkg::ALU_SLT;
                    3'b001:  o_ctrl.alu_op = rv_isa_pkg::ALU_SLL;
                    default: o_ctrl.alu_op = rv_isa_pkg::ALU_SRL;
                endcase
                if (func7 != rv_isa_pkg::FUNC7_BASE &&
                    !(func7 == rv_isa_pkg::FUNC7_ALT && func3 == 3'b000)) begin
                    o_ctrl = '0;
                end
                if (func3 == 3'b011) begin
                    o_ctrl = '0;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                o_ctrl.reg_we  = 1'b1;
                o_ctrl.alu_src = 1'b1;
                case (func3)
                    3'b000:  o_ctrl.alu_op = rv_isa_pkg::ALU_ADD;
                    3'b111:  o_ctrl.alu_op = rv_isa_pkg::ALU_AND;
                    3'b110:  o_ctrl.alu_op = rv_isa_pkg::ALU_OR;
                    default: o_ctrl = '0;
                endcase
            end
            rv_isa_pkg::OPC_LOAD: begin
                if (func3 == rv_isa_pkg::FUNC3_DW) begin
                    o_ctrl.reg_we     = 1'b1;
                    o_ctrl.alu_src    = 1'b1;
                    o_ctrl.mem_access = 1'b1;
                    o_ctrl.load_instr = 1'b1;
                    o_ctrl.result_src = rv_isa_pkg::RES_MEM;
                end
            end
            rv_isa_pkg::OPC_STORE: begin
                if (func3 == rv_isa_pkg::FUNC3_DW) begin
                    o_ctrl.alu_src    = 1'b1;
                    o_ctrl.mem_we     = 1'b1;
                    o_ctrl.mem_access = 1'b1;
                end
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (func3 == 3'b000 || func3 == 3'b001) begin
                    o_ctrl.branch    = 1'b1;
                    o_ctrl.branch_ne = func3[0];
                end
            end
            rv_isa_pkg::OPC_JAL: begin
                o_ctrl.reg_we     = 1'b1;
                o_ctrl.jump       = 1'b1;
                o_ctrl.result_src = rv_isa_pkg::RES_PC4;
            end
            default: o_ctrl = '0;
        endcase
    end

    // Immediate formats, all sign extended from bit 31.
    always_comb begin
        case (rv_isa_pkg::opcode_e'(opcode))
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_LOAD:   o_imm_ext = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
            rv_isa_pkg::OPC_STORE:  o_imm_ext = {{(XLEN-12){i_instr[31]}}, i_instr[31:25],
                                                 i_instr[11:7]};
            rv_isa_pkg::OPC_BRANCH: o_imm_ext = {{(XLEN-13){i_instr[31]}}, i_instr[31],
                                                 i_instr[7], i_instr[30:25],
                                                 i_instr[11:8], 1'b0};
            rv_isa_pkg::OPC_JAL:    o_imm_ext = {{(XLEN-21){i_instr[31]}}, i_instr[31],
                                                 i_instr[19:12], i_instr[20],
                                                 i_instr[30:21], 1'b0};
            default:                o_imm_ext = '0;
        endcase
    end

endmodule

//--- src/reg_file.sv
module reg_file (
    input  logic                            i_clk,
    input  logic                            i_arst,
    input  logic [rv_isa_pkg::REG_AW-1:0]   i_rs1_addr,
    input  logic [rv_isa_pkg::REG_AW-1:0]   i_rs2_addr,
    input  pipe_pkg::wb_t                   i_wb,
    output logic [rv_isa_pkg::XLEN-1:0]     o_rs1_data,
    output logic [rv_isa_pkg::XLEN-1:0]     o_rs2_data
);

    localparam int NREGS = 2 ** rv_isa_pkg::REG_AW;

    logic [rv_isa_pkg::XLEN-1:0] regs [NREGS];

    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we && i_wb.addr != '0) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // Reads see a write to the same register in the same cycle.
    always_comb begin
        if (i_rs1_addr == '0) begin
            o_rs1_data = '0;
        end else if (i_wb.we && i_wb.addr == i_rs1_addr) begin
            o_rs1_data = i_wb.data;
        end else begin
            o_rs1_data = regs[i_rs1_addr];
        end
    end

    always_comb begin
        if (i_rs2_addr == '0) begin
            o_rs2_data = '0;
        end else if (i_wb.we && i_wb.addr == i_rs2_addr) begin
            o_rs2_data = i_wb.data;
        end else begin
            o_rs2_data = regs[i_rs2_addr];
        end
    end

endmodule

//--- src/preg_decode.sv
module preg_decode (
    input  logic             i_clk,
    input  logic             i_arst,
    input  logic             i_stall_exec,
    input  logic             i_flush_exec,
    input  pipe_pkg::id_ex_t i_id,
    output pipe_pkg::id_ex_t o_ex_stage
);

    // Reset wins over flush, flush over stall, and stall over capture.
    // A flushed entry is all zero, which the execute stage treats as a bubble.
    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            o_ex_stage <= '0;
        end else if (i_flush_exec) begin
            o_ex_stage <= '0;
        end else if (!i_stall_exec) begin
            o_ex_stage <= i_id;
        end
    end

endmodule

//--- src/hazard_unit.sv
module hazard_unit (
    input  logic [rv_isa_pkg::REG_AW-1:0] i_rs1_addr,
    input  logic [rv_isa_pkg::REG_AW-1:0] i_rs2_addr,
    input  pipe_pkg::id_ex_t              i_ex_stage,
    input  logic                          i_branch_taken,
    output logic                          o_stall_fetch,
    output logic                          o_stall_exec,
    output logic                          o_flush_exec
);

    logic load_use;

    // A load in execute whose target is read by the instruction in decode.
    assign load_use = i_ex_stage.ctrl.load_instr &&
                      (i_ex_stage.rd_addr != '0) &&
                      ((i_ex_stage.rd_addr == i_rs1_addr) ||
                       (i_ex_stage.rd_addr == i_rs2_addr));

    // On a redirect the decode instruction is discarded, so holding fetch
    // would only replay a dead instruction.
    assign o_stall_fetch = load_use && !i_branch_taken;
    assign o_flush_exec  = load_use || i_branch_taken;

    // Nothing downstream can push back yet.
    assign o_stall_exec = 1'b0;

endmodule

//--- src/alu_exec.sv
module alu_exec (
    input  pipe_pkg::id_ex_t              i_ex_stage,
    output pipe_pkg::ex_out_t             o_ex,
    output logic                          o_branch_taken,
    output logic [rv_isa_pkg::XLEN-1:0]   o_pc_target
);

    localparam int XLEN = rv_isa_pkg::XLEN;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [5:0]      shamt;
    logic            cond_pass;

    assign op_a  = i_ex_stage.rs1_data;
    assign op_b  = i_ex_stage.ctrl.alu_src ? i_ex_stage.imm_ext : i_ex_stage.rs2_data;
    assign shamt = op_b[5:0];

    always_comb begin
        case (i_ex_stage.ctrl.alu_op)
            rv_isa_pkg::ALU_ADD: alu_result = op_a + op_b;
            rv_isa_pkg::ALU_SUB: alu_result = op_a - op_b;
            rv_isa_pkg::ALU_AND: alu_result = op_a & op_b;
            rv_isa_pkg::ALU_OR:  alu_result = op_a | op_b;
            rv_isa_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            rv_isa_pkg::ALU_SLT: alu_result = {{(XLEN-1){1'b0}},
                                               $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_SLL: alu_result = op_a << shamt;
            rv_isa_pkg::ALU_SRL: alu_result = op_a >> shamt;
            default:             alu_result = '0;
        endcase
    end

    // BEQ and BNE share one comparator; branch_ne flips the sense.
    assign cond_pass      = (i_ex_stage.rs1_data == i_ex_stage.rs2_data) ^
                            i_ex_stage.ctrl.branch_ne;
    assign o_branch_taken = (i_ex_stage.ctrl.branch && cond_pass) || i_ex_stage.ctrl.jump;
    assign o_pc_target    = i_ex_stage.pc + i_ex_stage.imm_ext;

    always_comb begin
        o_ex.reg_we     = i_ex_stage.ctrl.reg_we;
        o_ex.rd_addr    = i_ex_stage.rd_addr;
        o_ex.mem_we     = i_ex_stage.ctrl.mem_we;
        o_ex.mem_access = i_ex_stage.ctrl.mem_access;
        o_ex.load_instr = i_ex_stage.ctrl.load_instr;
        o_ex.store_data = i_ex_stage.rs2_data;
        // Memory operations pass the address on; the load data joins later.
        if (i_ex_stage.ctrl.result_src == rv_isa_pkg::RES_PC4) begin
            o_ex.result = i_ex_stage.pc_plus4;
        end else begin
            o_ex.result = alu_result;
        end
    end

endmodule

//--- src/decode_exec_top.sv
module decode_exec_top (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  logic [31:0]                   i_instr,
    input  logic [rv_isa_pkg::XLEN-1:0]   i_pc,
    input  pipe_pkg::wb_t                 i_wb,
    output logic                          o_stall_fetch,
    output logic                          o_branch_taken,
    output logic [rv_isa_pkg::XLEN-1:0]   o_pc_target,
    output pipe_pkg::ex_out_t             o_ex
);

    pipe_pkg::ctrl_t               ctrl;
    logic [rv_isa_pkg::XLEN-1:0]   imm_ext;
    logic [rv_isa_pkg::XLEN-1:0]   rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]   rs2_data;
    pipe_pkg::id_ex_t              id_stage;
    pipe_pkg::id_ex_t              ex_stage;
    logic                          stall_exec;
    logic                          flush_exec;
    logic                          branch_taken;

    instr_decoder u_decoder (
        .i_instr   (i_instr),
        .o_ctrl    (ctrl),
        .o_imm_ext (imm_ext)
    );

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_arst     (i_arst),
        .i_rs1_addr (i_instr[19:15]),
        .i_rs2_addr (i_instr[24:20]),
        .i_wb       (i_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    // Gather the decode-stage view of the instruction.
    assign id_stage.ctrl     = ctrl;
    assign id_stage.pc       = i_pc;
    assign id_stage.pc_plus4 = i_pc + rv_isa_pkg::XLEN'(4);
    assign id_stage.imm_ext  = imm_ext;
    assign id_stage.rs1_data = rs1_data;
    assign id_stage.rs2_data = rs2_data;
    assign id_stage.rs1_addr = i_instr[19:15];
    assign id_stage.rs2_addr = i_instr[24:20];
    assign id_stage.rd_addr  = i_instr[11:7];
    assign id_stage.func3    = i_instr[14:12];

    preg_decode u_preg_decode (
        .i_clk        (i_clk),
        .i_arst       (i_arst),
        .i_stall_exec (stall_exec),
        .i_flush_exec (flush_exec),
        .i_id         (id_stage),
        .o_ex_stage   (ex_stage)
    );

    hazard_unit u_hazard (
        .i_rs1_addr     (id_stage.rs1_addr),
        .i_rs2_addr     (id_stage.rs2_addr),
        .i_ex_stage     (ex_stage),
        .i_branch_taken (branch_taken),
        .o_stall_fetch  (o_stall_fetch),
        .o_stall_exec   (stall_exec),
        .o_flush_exec   (flush_exec)
    );

    alu_exec u_alu_exec (
        .i_ex_stage     (ex_stage),
        .o_ex           (o_ex),
        .o_branch_taken (branch_taken),
        .o_pc_target    (o_pc_target)
    );

    assign o_branch_taken = branch_taken;

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
    output logic o_clk
);

    localparam int PERIOD = 100;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

//--- testbench/decode_exec_asserts.sv
module decode_exec_asserts (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  logic [31:0]                   i_instr,
    input  logic [rv_isa_pkg::XLEN-1:0]   i_pc,
    input  pipe_pkg::wb_t                 i_wb,
    input  logic                          i_stall_fetch,
    input  logic                          i_branch_taken,
    input  logic [rv_isa_pkg::XLEN-1:0]   i_pc_target,
    input  pipe_pkg::ex_out_t             i_ex
);

    localparam int XLEN = rv_isa_pkg::XLEN;

    logic [XLEN-1:0] shadow [32];
    logic [31:0]     prev_instr;
    logic [XLEN-1:0] prev_pc;
    logic [XLEN-1:0] prev_a;
    logic [XLEN-1:0] prev_b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] exp_result;
    logic [XLEN-1:0] exp_target;
    logic            exp_reg_we;
    logic            exp_mem_we;
    logic            exp_load;
    logic            exp_taken;
    logic            stall_pred;
    int              fail_count = 0;

    // Register read as seen in decode, including a write in the same cycle.
    function automatic logic [XLEN-1:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (i_wb.we && i_wb.addr == addr) begin
            return i_wb.data;
        end
        return shadow[addr];
    endfunction

    assign imm_i = {{(XLEN-12){prev_instr[31]}}, prev_instr[31:20]};
    assign imm_s = {{(XLEN-12){prev_instr[31]}}, prev_instr[31:25], prev_instr[11:7]};
    assign imm_b = {{(XLEN-13){prev_instr[31]}}, prev_instr[31], prev_instr[7],
                    prev_instr[30:25], prev_instr[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){prev_instr[31]}}, prev_instr[31], prev_instr[19:12],
                    prev_instr[20], prev_instr[30:21], 1'b0};

    // Expected execute outputs for the instruction accepted at the last edge.
    always_comb begin
        exp_reg_we = 1'b0;
        exp_mem_we = 1'b0;
        exp_load   = 1'b0;
        exp_taken  = 1'b0;
        exp_result = '0;
        exp_target = prev_pc + imm_b;
        case (rv_isa_pkg::opcode_e'(prev_instr[6:0]))
            rv_isa_pkg::OPC_OP: begin
                exp_reg_we = 1'b1;
                case ({prev_instr[31:25], prev_instr[14:12]})
                    {7'h00, 3'b000}: exp_result = prev_a + prev_b;
                    {7'h20, 3'b000}: exp_result = prev_a - prev_b;
                    {7'h00, 3'b111}: exp_result = prev_a & prev_b;
                    {7'h00, 3'b110}: exp_result = prev_a | prev_b;
                    {7'h00, 3'b100}: exp_result = prev_a ^ prev_b;
                    {7'h00, 3'b010}: exp_result = {{(XLEN-1){1'b0}},
                                                   $signed(prev_a) < $signed(prev_b)};
                    {7'h00, 3'b001}: exp_result = prev_a << prev_b[5:0];
                    {7'h00, 3'b101}: exp_result = prev_a >> prev_b[5:0];
                    default:         exp_reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                exp_reg_we = 1'b1;
                case (prev_instr[14:12])
                    3'b000:  exp_result = prev_a + imm_i;
                    3'b111:  exp_result = prev_a & imm_i;
                    3'b110:  exp_result = prev_a | imm_i;
                    default: exp_reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LOAD: begin
                exp_reg_we = (prev_instr[14:12] == 3'b011);
                exp_load   = (prev_instr[14:12] == 3'b011);
                exp_result = prev_a + imm_i;
            end
            rv_isa_pkg::OPC_STORE: begin
                exp_mem_we = (prev_instr[14:12] == 3'b011);
                exp_result = prev_a + imm_s;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (prev_instr[14:12] == 3'b000) begin
                    exp_taken = (prev_a == prev_b);
                end else if (prev_instr[14:12] == 3'b001) begin
                    exp_taken = (prev_a != prev_b);
                end
            end
            rv_isa_pkg::OPC_JAL: begin
                exp_reg_we = 1'b1;
                exp_taken  = 1'b1;
                exp_result = prev_pc + 64'd4;
                exp_target = prev_pc + imm_j;
            end
            default: exp_reg_we = 1'b0;
        endcase
    end

    assign stall_pred = exp_load && (prev_instr[11:7] != 5'd0) &&
                        ((prev_instr[11:7] == i_instr[19:15]) ||
                         (prev_instr[11:7] == i_instr[24:20])) &&
                        !exp_taken;

    // A stalled or redirected decode instruction leaves a bubble behind.
    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            for (int r = 0; r < 32; r++) begin
                shadow[r] <= '0;
            end
            prev_instr <= '0;
            prev_pc    <= '0;
            prev_a     <= '0;
            prev_b     <= '0;
        end else begin
            if (stall_pred || exp_taken) begin
                prev_instr <= '0;
            end else begin
                prev_instr <= i_instr;
            end
            prev_pc <= i_pc;
            prev_a  <= read_reg(i_instr[19:15]);
            prev_b  <= read_reg(i_instr[24:20]);
            if (i_wb.we && i_wb.addr != 5'd0) begin
                shadow[i_wb.addr] <= i_wb.data;
            end
        end
    end

    a_controls: assert property (@(posedge i_clk) disable iff (i_arst)
        i_ex.reg_we == exp_reg_we && i_ex.mem_we == exp_mem_we &&
        i_ex.load_instr == exp_load && i_ex.mem_access == (exp_load || exp_mem_we))
    else begin
        fail_count = fail_count + 1;
        $error("Error at %0t: execute control fields are wrong", $time);
    end

    a_rd_addr: assert property (@(posedge i_clk) disable iff (i_arst)
        exp_reg_we |-> i_ex.rd_addr == prev_instr[11:7])
    else begin
        fail_count = fail_count + 1;
        $error("Error at %0t: rd_addr is %0d", $time, i_ex.rd_addr);
    end

    a_result: assert property (@(posedge i_clk) disable iff (i_arst)
        (exp_reg_we || exp_mem_we) |-> i_ex.result == exp_result)
    else begin
        fail_count = fail_count + 1;
        $error("Error at %0t: result %h, expected %h", $time, i_ex.result, exp_result);
    end

    a_store_data: assert property (@(posedge i_clk) disable iff (i_arst)
        exp_mem_we |-> i_ex.store_data == prev_b)
    else begin
        fail_count = fail_count + 1;
        $error("Error at %0t: store data %h, expected %h", $time, i_ex.store_data, prev_b);
    end

    a_branch: assert property (@(posedge i_clk) disable iff (i_arst)
        i_branch_taken == exp_taken && (!exp_taken || i_pc_target == exp_target))
    else begin
        fail_count = fail_count + 1;
        $error("Error at %0t: branch taken %b, target %h", $time, i_branch_taken,
               i_pc_target);
    end

    a_stall: assert property (@(posedge i_clk) disable iff (i_arst)
        i_stall_fetch == stall_pred)
    else begin
        fail_count = fail_count + 1;
        $error("Error at %0t: fetch stall is %b", $time, i_stall_fetch);
    end

endmodule

//--- testbench/tb_decode_exec.sv
module tb_decode_exec;

    localparam int XLEN    = rv_isa_pkg::XLEN;
    localparam int N_INSTR = 21;
    localparam int N_REGS  = 32;

    logic              clk;
    logic              arst;
    logic [31:0]       instr;
    logic [XLEN-1:0]   pc;
    pipe_pkg::wb_t     wb;
    logic              stall_fetch;
    logic              branch_taken;
    logic [XLEN-1:0]   pc_target;
    pipe_pkg::ex_out_t ex;
    logic [31:0]       prog [N_INSTR];
    pipe_pkg::wb_t     prog_wb [N_INSTR];
    integer            seed = 83885;
    int                seq_errors = 0;
    int                stall_cycles = 0;

    tb_clock u_clock (
        .o_clk (clk)
    );

    decode_exec_top dut0 (
        .i_clk          (clk),
        .i_arst         (arst),
        .i_instr        (instr),
        .i_pc           (pc),
        .i_wb           (wb),
        .o_stall_fetch  (stall_fetch),
        .o_branch_taken (branch_taken),
        .o_pc_target    (pc_target),
        .o_ex           (ex)
    );

    bind decode_exec_top decode_exec_asserts u_asserts (
        .i_clk          (i_clk),
        .i_arst         (i_arst),
        .i_instr        (i_instr),
        .i_pc           (i_pc),
        .i_wb           (i_wb),
        .i_stall_fetch  (o_stall_fetch),
        .i_branch_taken (o_branch_taken),
        .i_pc_target    (o_pc_target),
        .i_ex           (o_ex)
    );

    function automatic logic [4:0] pick_reg();
        return 5'(1 + ({$random(seed)} % 31));
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {f7, rs2, rs1, f3, pick_reg(), rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], rv_isa_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    // Instruction 13 depends on the load before it, and instruction 19 reads a register
    // that is written in the same cycle. Fillers after BEQ and JAL are discarded.
    task automatic build_program();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rl;
        ra = pick_reg();
        rb = pick_reg();
        rl = pick_reg();
        prog[0]  = rtype_word(7'h00, rb, ra, 3'b000);
        prog[1]  = rtype_word(7'h20, rb, ra, 3'b000);
        prog[2]  = rtype_word(7'h00, rb, ra, 3'b111);
        prog[3]  = rtype_word(7'h00, rb, ra, 3'b110);
        prog[4]  = rtype_word(7'h00, rb, ra, 3'b100);
        prog[5]  = rtype_word(7'h00, rb, ra, 3'b010);
        prog[6]  = rtype_word(7'h00, rb, ra, 3'b001);
        prog[7]  = rtype_word(7'h00, rb, ra, 3'b101);
        prog[8]  = itype_word(12'($random(seed)), 5'd0, 3'b000, pick_reg(),
                              rv_isa_pkg::OPC_OP_IMM);
        prog[9]  = itype_word(12'($random(seed)), ra, 3'b111, pick_reg(),
                              rv_isa_pkg::OPC_OP_IMM);
        prog[10] = itype_word(12'($random(seed)), ra, 3'b110, pick_reg(),
                              rv_isa_pkg::OPC_OP_IMM);
        prog[11] = stype_word(12'($random(seed)), rb, ra);
        prog[12] = itype_word(12'($random(seed)), ra, 3'b011, rl, rv_isa_pkg::OPC_LOAD);
        prog[13] = rtype_word(7'h00, rb, rl, 3'b000);
        prog[14] = btype_word(13'h1ff8, ra, ra, 3'b001);
        prog[15] = btype_word(13'h0010, rb, rb, 3'b000);
        prog[16] = itype_word(12'h001, ra, 3'b000, pick_reg(), rv_isa_pkg::OPC_OP_IMM);
        prog[17] = jtype_word(21'h1ffff0, pick_reg());
        prog[18] = itype_word(12'h002, ra, 3'b000, pick_reg(), rv_isa_pkg::OPC_OP_IMM);
        prog[19] = rtype_word(7'h00, rb, ra, 3'b100);
        prog[20] = rtype_word(7'h00, rb, ra, 3'b000);
        for (int i = 0; i < N_INSTR; i++) begin
            prog_wb[i] = '0;
        end
        prog_wb[19].we   = 1'b1;
        prog_wb[19].addr = ra;
        prog_wb[19].data = {$random(seed), $random(seed)};
    endtask

    // Every register is written, x0 included, which must keep reading zero.
    task automatic load_registers();
        pipe_pkg::wb_t req;
        for (int r = 0; r < N_REGS; r++) begin
            @(posedge clk);
            req.we   = 1'b1;
            req.addr = 5'(r);
            req.data = {$random(seed), $random(seed)};
            wb <= req;
        end
    endtask

    // Fetch moves on unless the decode instruction was stalled at this edge.
    task automatic run_program();
        int k;
        int held;
        k = 0;
        held = 0;
        @(posedge clk);
        instr <= prog[0];
        pc    <= 64'h1000;
        wb    <= prog_wb[0];
        while (k < N_INSTR) begin
            @(posedge clk);
            if (stall_fetch) begin
                held++;
                stall_cycles++;
                if (held > 1) begin
                    seq_errors++;
                    $display("Fetch stayed stalled for more than one cycle at time %0t", $time);
                end
            end else begin
                held = 0;
                k++;
                if (k < N_INSTR) begin
                    instr <= prog[k];
                    pc    <= 64'h1000 + 64'(4 * k);
                    wb    <= prog_wb[k];
                end else begin
                    instr <= '0;
                    wb    <= '0;
                end
            end
        end
    endtask

    initial begin
        arst  = 1'b1;
        instr = '0;
        pc    = '0;
        wb    = '0;
        build_program();
        repeat (3) @(posedge clk);
        arst <= 1'b0;
        load_registers();
        run_program();
        repeat (3) @(posedge clk);
        if (stall_cycles != 1) begin
            seq_errors++;
            $display("Expected one load-use stall cycle but saw %0d", stall_cycles);
        end
        $display("Run complete: %0d assertion failures, %0d sequencing failures",
                 dut0.u_asserts.fail_count, seq_errors);
        if (dut0.u_asserts.fail_count + seq_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (N_INSTR + N_REGS + 20) @(posedge clk);
        $display("The run timed out before the instruction list completed");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sources.f
src/rv_isa_pkg.sv
src/pipe_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/preg_decode.sv
src/hazard_unit.sv
src/alu_exec.sv
src/decode_exec_top.sv
testbench/tb_clock.sv
testbench/decode_exec_asserts.sv
testbench/tb_decode_exec.sv

//--- run.sh
#!/bin/sh
# Builds the simulation with Verilator, runs it and checks the result line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_decode_exec -f sources.f -o sim_decode_exec
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Assertion errors must not stop the run before the summary is printed.
out=$(./obj_dir/sim_decode_exec +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
